/* list.f */
+incdir+rtl
+incdir+tests
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/scoreboard.sv
rtl/decode_issue.sv
rtl/execute_wb.sv
rtl/io_port.sv
rtl/mini_core.sv
tests/mini_core_tb.sv

/* rtl/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Word address of the memory mapped IO store
`define IO_ADDR     32'h00010000
`define RESET_PC    32'h00000000

// Major opcodes of the supported instructions
`define OP_REG      7'b0110011
`define OP_IMM      7'b0010011
`define OP_LUI      7'b0110111
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_SYSTEM   7'b1110011

`define EBREAK_WORD 32'h00100073

`endif

/* rtl/core_pkg.sv */
package core_pkg;

	typedef logic [31:0] word_t;     // Data and address word
	typedef logic [4:0]  reg_idx_t;  // x0 always reads as zero
	typedef logic [6:0]  opcode_t;   // Major opcode field

	// Register-register view
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;          // ADDI immediate or upper bits of a U immediate
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		opcode_t     opcode;
	} i_fmt_t;

	// Store view that also carries the scrambled B immediate
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} s_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
	} instr_u;

	// Operations handed to the back end
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_LUI,
		ALU_STORE,
		ALU_BEQ,
		ALU_BNE,
		ALU_NOP
	} alu_op_t;

endpackage

/* rtl/decode_issue.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module decode_issue (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_valid,
	input  core_pkg::instr_u   i_instr,
	input  core_pkg::word_t    i_pc,
	input  logic               i_flush,
	input  logic               i_wb_valid,
	input  core_pkg::reg_idx_t i_wb_rd,
	input  core_pkg::word_t    i_wb_data,
	output logic               o_stall,
	output core_pkg::alu_op_t  o_op,
	output core_pkg::word_t    o_a,
	output core_pkg::word_t    o_b,
	output core_pkg::word_t    o_imm,
	output core_pkg::word_t    o_pc,
	output core_pkg::reg_idx_t o_rd,
	output logic               o_issue_valid,
	output logic               o_halt,
	output core_pkg::word_t    o_halt_pc
);
	import core_pkg::*;

	word_t    rf [32];     // x0 entry never written
	alu_op_t  dec_op;
	reg_idx_t dec_rd;
	word_t    dec_imm;
	logic     use_rs1;
	logic     use_rs2;
	logic     b_is_imm;    // ADDI takes its immediate as operand b
	logic     is_ebreak;
	word_t    rs1_val;
	word_t    rs2_val;
	logic     sb_stall;
	logic     accept;
	logic     halted_q;
	word_t    halt_pc_q;

	always_comb begin
		dec_op    = ALU_NOP;
		dec_rd    = '0;
		dec_imm   = '0;
		use_rs1   = 1'b0;
		use_rs2   = 1'b0;
		b_is_imm  = 1'b0;
		is_ebreak = 1'b0;
		case (i_instr.r.opcode)
			`OP_REG: begin
				dec_op  = (i_instr.r.funct7 == 7'h20) ? ALU_SUB : ALU_ADD;
				dec_rd  = i_instr.r.rd;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			`OP_IMM: begin
				if (i_instr.i.funct3 == 3'b000) begin  // ADDI only
					dec_op   = ALU_ADD;
					dec_rd   = i_instr.i.rd;
					dec_imm  = {{20{i_instr.i.imm[11]}}, i_instr.i.imm};
					use_rs1  = 1'b1;
					b_is_imm = 1'b1;
				end
			end
			`OP_LUI: begin
				dec_op  = ALU_LUI;
				dec_rd  = i_instr.i.rd;
				dec_imm = {i_instr.i.imm, i_instr.i.rs1, i_instr.i.funct3, 12'd0};
			end
			`OP_STORE: begin
				if (i_instr.s.funct3 == 3'b010) begin  // SW
					dec_op  = ALU_STORE;
					dec_imm = {{20{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi, i_instr.s.imm_lo};
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			`OP_BRANCH: begin
				if (i_instr.s.funct3 == 3'b000 || i_instr.s.funct3 == 3'b001) begin
					dec_op  = i_instr.s.funct3[0] ? ALU_BNE : ALU_BEQ;
					// B immediate rebuilt from the store fields
					dec_imm = {{19{i_instr.s.imm_hi[6]}}, i_instr.s.imm_hi[6], i_instr.s.imm_lo[0],
						i_instr.s.imm_hi[5:0], i_instr.s.imm_lo[4:1], 1'b0};
					use_rs1 = 1'b1;
					use_rs2 = 1'b1;
				end
			end
			`OP_SYSTEM: begin
				is_ebreak = (i_instr == `EBREAK_WORD);
			end
			default: begin
				dec_op = ALU_NOP;
			end
		endcase
	end

	// Register read with write-through from the back end
	assign rs1_val = (i_instr.r.rs1 == 5'd0) ? 32'd0
		: (i_wb_valid && i_wb_rd == i_instr.r.rs1) ? i_wb_data : rf[i_instr.r.rs1];
	assign rs2_val = (i_instr.r.rs2 == 5'd0) ? 32'd0
		: (i_wb_valid && i_wb_rd == i_instr.r.rs2) ? i_wb_data : rf[i_instr.r.rs2];

	always_ff @(posedge clk) begin
		if (i_wb_valid && i_wb_rd != 5'd0) begin
			rf[i_wb_rd] <= i_wb_data;
		end
	end

	scoreboard scoreboard_inst (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_rs1        (i_instr.r.rs1),
		.i_rs2        (i_instr.r.rs2),
		.i_use_rs1    (use_rs1),
		.i_use_rs2    (use_rs2),
		.i_issue_valid(accept && !is_ebreak),
		.i_issue_rd   (dec_rd),
		.i_wb_valid   (i_wb_valid),
		.i_wb_rd      (i_wb_rd),
		.o_stall      (sb_stall)
	);

	assign o_stall = i_valid && (sb_stall || halted_q);  // Fetch holds its word
	assign accept  = i_valid && !o_stall && !i_flush;    // Wrong path word dropped on flush

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_issue_valid <= 1'b0;
			halted_q      <= 1'b0;
		end else begin
			o_issue_valid <= accept && !is_ebreak;
			if (accept && is_ebreak) begin
				halted_q <= 1'b1;  // Sticky until reset
			end
		end
		if (accept) begin
			o_op  <= dec_op;
			o_a   <= rs1_val;
			o_b   <= b_is_imm ? dec_imm : rs2_val;
			o_imm <= dec_imm;
			o_pc  <= i_pc;
			o_rd  <= dec_rd;
		end
		if (accept && is_ebreak) begin
			halt_pc_q <= i_pc;
		end
	end

	assign o_halt    = halted_q;
	assign o_halt_pc = halt_pc_q;

endmodule

/* rtl/execute_wb.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module execute_wb (
	input  logic               clk,
	input  logic               i_rst,
	input  logic               i_issue_valid,
	input  core_pkg::alu_op_t  i_op,
	input  core_pkg::word_t    i_a,
	input  core_pkg::word_t    i_b,
	input  core_pkg::word_t    i_imm,
	input  core_pkg::word_t    i_pc,
	input  core_pkg::reg_idx_t i_rd,
	output logic               o_wb_valid,
	output core_pkg::reg_idx_t o_wb_rd,
	output core_pkg::word_t    o_wb_data,
	output logic               o_redirect_valid,
	output core_pkg::word_t    o_redirect_pc,
	output logic               o_io_store_valid,
	output core_pkg::word_t    o_io_store_data
);
	import core_pkg::*;

	word_t result;
	word_t eff_addr;   // Store address rs1 + offset
	logic  writes;
	logic  taken;

	assign eff_addr = i_a + i_imm;

	always_comb begin
		result = i_a + i_b;
		writes = 1'b0;
		taken  = 1'b0;
		case (i_op)
			ALU_ADD: begin
				writes = 1'b1;
			end
			ALU_SUB: begin
				result = i_a - i_b;
				writes = 1'b1;
			end
			ALU_LUI: begin
				result = i_imm;  // Already shifted by decode
				writes = 1'b1;
			end
			ALU_BEQ: begin
				taken = (i_a == i_b);
			end
			ALU_BNE: begin
				taken = (i_a != i_b);
			end
			default: begin
				writes = 1'b0;   // STORE and NOP leave the register file alone
			end
		endcase
	end

	// Branch resolves in the same cycle
	assign o_redirect_valid = i_issue_valid && taken;
	assign o_redirect_pc    = i_pc + i_imm;

	// Only the IO word is a real store target
	assign o_io_store_valid = i_issue_valid && (i_op == ALU_STORE) && (eff_addr == `IO_ADDR);
	assign o_io_store_data  = i_b;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= i_issue_valid && writes && (i_rd != 5'd0);
		end
		o_wb_rd   <= i_rd;
		o_wb_data <= result;
	end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module fetch_unit (
	input  logic             clk,
	input  logic             i_rst,
	input  logic             i_imem_valid,
	input  core_pkg::word_t  i_imem_data,
	input  logic             i_stall,
	input  logic             i_halt,
	input  logic             i_redirect_valid,
	input  core_pkg::word_t  i_redirect_pc,
	output logic             o_imem_req,
	output core_pkg::word_t  o_imem_addr,
	output logic             o_valid,
	output core_pkg::instr_u o_instr,
	output core_pkg::word_t  o_pc
);
	import core_pkg::*;

	word_t  pc_q;         // Next PC to request
	word_t  addr_q;       // Address of the outstanding request
	logic   req_q;
	logic   epoch_q;      // Flips on every redirect
	logic   req_epoch_q;  // Epoch the outstanding request was sent in
	logic   stop_q;       // EBREAK fetched so nothing more is requested
	logic   buf_valid_q;
	instr_u buf_instr_q;
	word_t  buf_pc_q;
	logic   rsp_done;
	logic   rsp_take;
	logic   rsp_ebreak;
	logic   buf_busy;
	logic   can_launch;
	logic   launch;

	assign rsp_done   = req_q && i_imem_valid;
	assign rsp_take   = rsp_done && (req_epoch_q == epoch_q) && !i_redirect_valid; // Stale words dropped
	assign rsp_ebreak = rsp_take && (i_imem_data == `EBREAK_WORD);
	assign buf_busy   = rsp_take || (buf_valid_q && i_stall);  // Buffer occupied next cycle
	assign can_launch = (!req_q || rsp_done) && !i_halt;      // Port free after this cycle
	assign launch     = can_launch && !buf_busy && !stop_q;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			pc_q        <= `RESET_PC;
			req_q       <= 1'b0;
			epoch_q     <= 1'b0;
			req_epoch_q <= 1'b0;
			stop_q      <= 1'b0;
			buf_valid_q <= 1'b0;
		end else if (i_redirect_valid) begin
			epoch_q     <= !epoch_q;
			stop_q      <= 1'b0;
			buf_valid_q <= 1'b0;
			if (can_launch) begin
				// Go straight to the target
				req_q       <= 1'b1;
				addr_q      <= i_redirect_pc;
				req_epoch_q <= !epoch_q;
				pc_q        <= i_redirect_pc + 32'd4;
			end else begin
				req_q <= req_q && !rsp_done;  // Old request still waits for its answer
				pc_q  <= i_redirect_pc;
			end
		end else begin
			stop_q      <= stop_q || rsp_ebreak;
			buf_valid_q <= buf_busy;
			if (launch) begin
				req_q       <= 1'b1;
				addr_q      <= pc_q;
				req_epoch_q <= epoch_q;
				pc_q        <= pc_q + 32'd4;
			end else if (rsp_done) begin
				req_q <= 1'b0;
			end
		end
	end

	// Response buffer payload
	always_ff @(posedge clk) begin
		if (rsp_take) begin
			buf_instr_q <= i_imem_data;
			buf_pc_q    <= addr_q;
		end
	end

	assign o_imem_req  = req_q;
	assign o_imem_addr = addr_q;
	assign o_valid     = buf_valid_q;
	assign o_instr     = buf_instr_q;
	assign o_pc        = buf_pc_q;

	// A waiting request holds its address until the memory answers
	assert property (@(posedge clk) disable iff (i_rst)
		o_imem_req && !i_imem_valid |=> o_imem_req && $stable(o_imem_addr));

endmodule

/* rtl/io_port.sv */
`timescale 1ns/1ns

module io_port (
	input  logic            clk,
	input  logic            i_rst,
	input  logic            i_store_valid,
	input  core_pkg::word_t i_store_data,
	input  logic            i_halt,
	input  core_pkg::word_t i_halt_pc,
	output logic            o_io_valid,
	output core_pkg::word_t o_io_data,
	output logic            o_ebreak,
	output core_pkg::word_t o_ebreak_pc
);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_io_valid <= 1'b0;
			o_ebreak   <= 1'b0;
		end else begin
			o_io_valid <= i_store_valid;       // One cycle pulse per store
			o_ebreak   <= o_ebreak || i_halt;  // Held until reset
		end
		if (i_store_valid) begin
			o_io_data <= i_store_data;
		end
		// First halt report wins
		if (i_halt && !o_ebreak) begin
			o_ebreak_pc <= i_halt_pc;
		end
	end

	// Core is quiet once EBREAK is reported
	assert property (@(posedge clk) disable iff (i_rst)
		o_ebreak |-> !o_io_valid);

endmodule

/* rtl/mini_core.sv */
`timescale 1ns/1ns

module mini_core (
	input  logic            clk,
	input  logic            i_rst,
	input  logic            i_imem_valid,
	input  core_pkg::word_t i_imem_data,
	output logic            o_imem_req,
	output core_pkg::word_t o_imem_addr,
	output logic            o_io_valid,
	output core_pkg::word_t o_io_data,
	output logic            o_ebreak,
	output core_pkg::word_t o_ebreak_pc
);
	import core_pkg::*;

	// Front end to decode
	logic     fetch_valid;
	instr_u   fetch_instr;
	word_t    fetch_pc;
	logic     issue_stall;
	// Decode to back end
	alu_op_t  issue_op;
	word_t    issue_a;
	word_t    issue_b;
	word_t    issue_imm;
	word_t    issue_pc;
	reg_idx_t issue_rd;
	logic     issue_valid;
	// Back end results
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_data;
	logic     redirect_valid;
	word_t    redirect_pc;
	logic     io_store_valid;
	word_t    io_store_data;
	logic     halt_seen;
	word_t    halt_pc;

	fetch_unit fetch_unit_inst (
		.clk             (clk),
		.i_rst           (i_rst),
		.i_imem_valid    (i_imem_valid),
		.i_imem_data     (i_imem_data),
		.i_stall         (issue_stall),
		.i_halt          (halt_seen),
		.i_redirect_valid(redirect_valid),
		.i_redirect_pc   (redirect_pc),
		.o_imem_req      (o_imem_req),
		.o_imem_addr     (o_imem_addr),
		.o_valid         (fetch_valid),
		.o_instr         (fetch_instr),
		.o_pc            (fetch_pc)
	);

	decode_issue decode_issue_inst (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_valid      (fetch_valid),
		.i_instr      (fetch_instr),
		.i_pc         (fetch_pc),
		.i_flush      (redirect_valid),   // Taken branch kills the next word
		.i_wb_valid   (wb_valid),
		.i_wb_rd      (wb_rd),
		.i_wb_data    (wb_data),
		.o_stall      (issue_stall),
		.o_op         (issue_op),
		.o_a          (issue_a),
		.o_b          (issue_b),
		.o_imm        (issue_imm),
		.o_pc         (issue_pc),
		.o_rd         (issue_rd),
		.o_issue_valid(issue_valid),
		.o_halt       (halt_seen),
		.o_halt_pc    (halt_pc)
	);

	execute_wb execute_wb_inst (
		.clk             (clk),
		.i_rst           (i_rst),
		.i_issue_valid   (issue_valid),
		.i_op            (issue_op),
		.i_a             (issue_a),
		.i_b             (issue_b),
		.i_imm           (issue_imm),
		.i_pc            (issue_pc),
		.i_rd            (issue_rd),
		.o_wb_valid      (wb_valid),
		.o_wb_rd         (wb_rd),
		.o_wb_data       (wb_data),
		.o_redirect_valid(redirect_valid),
		.o_redirect_pc   (redirect_pc),
		.o_io_store_valid(io_store_valid),
		.o_io_store_data (io_store_data)
	);

	io_port io_port_inst (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_store_valid(io_store_valid),
		.i_store_data (io_store_data),
		.i_halt       (halt_seen),
		.i_halt_pc    (halt_pc),
		.o_io_valid   (o_io_valid),
		.o_io_data    (o_io_data),
		.o_ebreak     (o_ebreak),
		.o_ebreak_pc  (o_ebreak_pc)
	);

endmodule

/* rtl/scoreboard.sv */
`timescale 1ns/1ns

module scoreboard (
	input  logic               clk,
	input  logic               i_rst,
	input  core_pkg::reg_idx_t i_rs1,
	input  core_pkg::reg_idx_t i_rs2,
	input  logic               i_use_rs1,
	input  logic               i_use_rs2,
	input  logic               i_issue_valid,
	input  core_pkg::reg_idx_t i_issue_rd,
	input  logic               i_wb_valid,
	input  core_pkg::reg_idx_t i_wb_rd,
	output logic               o_stall
);
	logic [31:0] pending_q;  // One bit per register awaiting write-back
	logic [31:0] clr_mask;
	logic [31:0] set_mask;
	logic [31:0] live;       // Still pending once this write-back lands

	assign clr_mask = i_wb_valid ? (32'd1 << i_wb_rd) : 32'd0;
	assign set_mask = i_issue_valid ? (32'd1 << i_issue_rd) : 32'd0;
	assign live     = pending_q & ~clr_mask;

	// Write-back this cycle is bypassed so it does not stall
	// Destination checked too so two writes to one register stay ordered
	assign o_stall = (i_use_rs1 && live[i_rs1])
		|| (i_use_rs2 && live[i_rs2])
		|| live[i_issue_rd];

	always_ff @(posedge clk) begin
		if (i_rst) begin
			pending_q <= '0;
		end else begin
			pending_q <= (live | set_mask) & ~32'd1;  // x0 never pending
		end
	end

	// Back end only retires registers that decode marked pending
	assert property (@(posedge clk) disable iff (i_rst)
		i_wb_valid |-> pending_q[i_wb_rd]);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module mini_core_tb \
	&& ./obj_dir/Vmini_core_tb | tee sim.log \
	|| echo "Build or simulation did not complete"

grep -qs "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/mini_core_checks.svh */
`ifndef MINI_CORE_CHECKS_SVH
`define MINI_CORE_CHECKS_SVH

// Prints the verdict and ends the run
task automatic end_with_failure();
	$display("Errors found");
	$fatal(1, "simulation stopped at first error");
endtask

task automatic abort_run(input string why);
	$display("%s at time %0t", why, $time);
	end_with_failure();
endtask

task automatic check_word(input string name, input core_pkg::word_t got,
		input core_pkg::word_t exp);
	if (got !== exp) begin
		$display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAIL time %0t %s got %b expected %b", $time, name, got, exp);
		end_with_failure();
	end
endtask

task automatic wait_first_request();
	int cycles;
	cycles = 0;
	while (!o_imem_req) begin
		if (cycles == 20) begin
			abort_run("no instruction request after reset");
		end else begin
			@(negedge clk);
			cycles++;
		end
	end
endtask

// Gathers IO words sampled mid cycle until the halt report
task automatic collect_until_halt(input int p);
	int n;
	int cycles;
	n      = 0;
	cycles = 0;
	while (!o_ebreak) begin
		if (cycles == 600) begin
			abort_run($sformatf("program %0d did not reach EBREAK in time", p));
		end else begin
			@(negedge clk);
			cycles++;
			if (o_io_valid) begin
				if (n >= io_len[p]) begin
					abort_run($sformatf("program %0d made more IO stores than expected", p));
				end else begin
					check_word("o_io_data", o_io_data, io_tab[p][n]);
					n++;
				end
			end
		end
	end
	if (n != io_len[p]) begin
		abort_run($sformatf("program %0d made %0d IO stores instead of %0d", p, n, io_len[p]));
	end else begin
		check_word("o_ebreak_pc", o_ebreak_pc, halt_tab[p]);
	end
endtask

// Core must stay quiet once halted
task automatic watch_after_halt();
	repeat (10) begin
		@(negedge clk);
		check_bit("o_ebreak", o_ebreak, 1'b1);   // Sticky
		check_bit("o_io_valid", o_io_valid, 1'b0);
		check_bit("o_imem_req", o_imem_req, 1'b0);
	end
endtask

`endif

/* tests/mini_core_tb.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module mini_core_tb;
	import core_pkg::*;

	localparam int    NUM_PROGS = 4;
	localparam word_t NOP_WORD  = 32'h00000013;  // addi x0, x0, 0

	logic  clk;
	logic  i_rst;
	logic  i_imem_valid;
	word_t i_imem_data;
	logic  o_imem_req;
	word_t o_imem_addr;
	logic  o_io_valid;
	word_t o_io_data;
	logic  o_ebreak;
	word_t o_ebreak_pc;

	word_t prog_tab [NUM_PROGS][16];
	int    prog_len [NUM_PROGS];
	word_t io_tab   [NUM_PROGS][8];   // IO words in program order
	int    io_len   [NUM_PROGS];
	word_t halt_tab [NUM_PROGS];      // PC of the EBREAK
	int    cur;                       // Program the memory serves
	int    pending;
	int    delay;

	mini_core mini_core_inst (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_imem_valid(i_imem_valid),
		.i_imem_data (i_imem_data),
		.o_imem_req  (o_imem_req),
		.o_imem_addr (o_imem_addr),
		.o_io_valid  (o_io_valid),
		.o_io_data   (o_io_data),
		.o_ebreak    (o_ebreak),
		.o_ebreak_pc (o_ebreak_pc)
	);

	`include "mini_core_checks.svh"

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t imem_word(input word_t addr);
		if (addr[1:0] == 2'b00 && addr < 32'(prog_len[cur] * 4)) begin
			return prog_tab[cur][addr[5:2]];
		end
		return NOP_WORD;  // Past the end of the program
	endfunction

	// Instruction memory answers each request after 0 to 3 idle cycles
	initial begin
		void'($urandom(32'hce92c244));
		i_imem_valid = 1'b0;
		i_imem_data  = '0;
		pending      = 0;
		delay        = 0;
		forever begin
			@(posedge clk);
			#1;
			i_imem_valid = 1'b0;  // Previous answer taken at this edge
			if (pending == 0 && o_imem_req) begin
				pending = 1;
				delay   = $urandom % 4;
			end
			if (pending != 0) begin
				if (delay == 0) begin
					i_imem_valid = 1'b1;
					i_imem_data  = imem_word(o_imem_addr);
					pending      = 0;
				end else begin
					delay = delay - 1;
				end
			end
		end
	end

	// Hand encoded programs with IO words worked out from the ISA rules
	task automatic load_table();
		// Arithmetic
		prog_tab[0][0]  = 32'h000100B7;  // lui  x1, 0x10
		prog_tab[0][1]  = 32'h00500113;  // addi x2, x0, 5
		prog_tab[0][2]  = 32'h00C00193;  // addi x3, x0, 12
		prog_tab[0][3]  = 32'h00310233;  // add  x4, x2, x3
		prog_tab[0][4]  = 32'h0040A023;  // sw   x4, 0(x1)
		prog_tab[0][5]  = 32'h403102B3;  // sub  x5, x2, x3
		prog_tab[0][6]  = 32'h0050A023;  // sw   x5, 0(x1)
		prog_tab[0][7]  = 32'hABCDE337;  // lui  x6, 0xabcde
		prog_tab[0][8]  = 32'h0060A023;  // sw   x6, 0(x1)
		prog_tab[0][9]  = 32'hFFF00393;  // addi x7, x0, -1
		prog_tab[0][10] = 32'h0070A023;  // sw   x7, 0(x1)
		prog_tab[0][11] = `EBREAK_WORD;
		prog_len[0] = 12;
		io_tab[0][0] = 32'd5 + 32'd12;
		io_tab[0][1] = 32'd5 - 32'd12;  // Wraps below zero
		io_tab[0][2] = 32'hABCDE << 12;
		io_tab[0][3] = 32'hFFFFFFFF;    // Sign extended -1
		io_len[0]    = 4;
		halt_tab[0]  = 32'd44;
		// Back to back dependencies
		prog_tab[1][0]  = 32'h000100B7;  // lui  x1, 0x10
		prog_tab[1][1]  = 32'h00100113;  // addi x2, x0, 1
		prog_tab[1][2]  = 32'h00210113;  // addi x2, x2, 2
		prog_tab[1][3]  = 32'h002101B3;  // add  x3, x2, x2
		prog_tab[1][4]  = 32'h402181B3;  // sub  x3, x3, x2
		prog_tab[1][5]  = 32'h0030A023;  // sw   x3, 0(x1)
		prog_tab[1][6]  = 32'h06418213;  // addi x4, x3, 100
		prog_tab[1][7]  = 32'h0040A023;  // sw   x4, 0(x1)
		prog_tab[1][8]  = `EBREAK_WORD;
		prog_len[1] = 9;
		io_tab[1][0] = 32'd6 - 32'd3;   // (1 + 2) doubled then minus 3
		io_tab[1][1] = 32'd3 + 32'd100;
		io_len[1]    = 2;
		halt_tab[1]  = 32'd32;
		// Branches and a countdown loop
		prog_tab[2][0]  = 32'h000100B7;  // lui  x1, 0x10
		prog_tab[2][1]  = 32'h00300113;  // addi x2, x0, 3
		prog_tab[2][2]  = 32'h0020A023;  // sw   x2, 0(x1)
		prog_tab[2][3]  = 32'hFFF10113;  // addi x2, x2, -1
		prog_tab[2][4]  = 32'hFE011CE3;  // bne  x2, x0, -8
		prog_tab[2][5]  = 32'h00010463;  // beq  x2, x0, +8 taken
		prog_tab[2][6]  = 32'h0010A023;  // sw   x1, 0(x1) skipped
		prog_tab[2][7]  = 32'h00008463;  // beq  x1, x0, +8 not taken
		prog_tab[2][8]  = 32'h00700193;  // addi x3, x0, 7
		prog_tab[2][9]  = 32'h00319463;  // bne  x3, x3, +8 not taken
		prog_tab[2][10] = 32'h0030A023;  // sw   x3, 0(x1)
		prog_tab[2][11] = `EBREAK_WORD;
		prog_len[2] = 12;
		io_tab[2][0] = 32'd3;
		io_tab[2][1] = 32'd2;
		io_tab[2][2] = 32'd1;
		io_tab[2][3] = 32'd7;
		io_len[2]    = 4;
		halt_tab[2]  = 32'd44;
		// Stores off the IO word and a store after the halt
		prog_tab[3][0]  = 32'h000100B7;  // lui  x1, 0x10
		prog_tab[3][1]  = 32'h02A00113;  // addi x2, x0, 42
		prog_tab[3][2]  = 32'h0020A223;  // sw   x2, 4(x1)
		prog_tab[3][3]  = 32'h00202023;  // sw   x2, 0(x0)
		prog_tab[3][4]  = 32'h0020A023;  // sw   x2, 0(x1)
		prog_tab[3][5]  = `EBREAK_WORD;
		prog_tab[3][6]  = 32'h0020A023;  // Never reached
		prog_len[3] = 7;
		io_tab[3][0] = 32'd42;
		io_len[3]    = 1;
		halt_tab[3]  = 32'd20;
	endtask

	initial begin
		i_rst = 1'b1;
		cur   = 0;
		load_table();
		// Second pass runs the same table under other response delays
		for (int pass = 0; pass < 2; pass++) begin
			for (int p = 0; p < NUM_PROGS; p++) begin
				@(posedge clk);
				#1;
				i_rst = 1'b1;
				cur   = p;
				repeat (2) @(posedge clk);
				#1;
				i_rst = 1'b0;
				@(negedge clk);
				check_bit("o_imem_req", o_imem_req, 1'b0);
				check_bit("o_io_valid", o_io_valid, 1'b0);
				check_bit("o_ebreak", o_ebreak, 1'b0);
				wait_first_request();
				check_word("o_imem_addr", o_imem_addr, `RESET_PC);  // Starts at reset PC
				collect_until_halt(p);
				watch_after_halt();
			end
		end
		$display("No errors");
		$finish;
	end

endmodule
